//--- verilog/link_pkg.sv
////////////////////////////////////////////////////////////
// link_pkg
// UART byte type, frame length type and command codes
////////////////////////////////////////////////////////////
package link_pkg;

    typedef logic [7:0] byte_t;    // one UART data byte
    typedef logic [7:0] len_t;     // payload byte count of a frame

    // first byte of every frame
    localparam byte_t CMD_WRITE = 8'h10;
    localparam byte_t CMD_READ  = 8'h11;

endpackage

//--- verilog/bus_pkg.sv
////////////////////////////////////////////////////////////
// bus_pkg
// memory bus word, address and request definitions
////////////////////////////////////////////////////////////
package bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    localparam int BYTES_PER_WORD = 4;    // byte lanes per data word

    // one single-beat access handed to the bus master
    typedef struct packed {
        logic  write;    // 1 for write, 0 for read
        addr_t addr;     // low two bits are ignored
        data_t data;     // don't care on reads
    } bus_req_t;

endpackage

//--- verilog/uart_rx.sv
////////////////////////////////////////////////////////////
// uart_rx
// 8N1 receiver, samples each bit at mid-period
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module uart_rx
    import link_pkg::*;
#(
    parameter int CLK_FREQ  = 100_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  rxd_i,
    output logic  rx_valid_o,
    output byte_t rx_byte_o
);

    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state_q;
    logic [1:0]       sync_q;    // metastability flops
    logic [CNT_W-1:0] cnt_q;
    logic [2:0]       bit_q;
    byte_t            shift_q;
    logic             valid_q;
    logic             rxd;
    logic             bit_end;

    assign rxd     = sync_q[1];
    assign bit_end = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            sync_q  <= 2'b11;    // line idles high
            state_q <= RX_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], rxd_i};
            valid_q <= 1'b0;
            cnt_q   <= cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (!rxd)
                        state_q <= RX_START;
                end
                RX_START: begin
                    // middle of start bit, reject glitches
                    if (cnt_q == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        cnt_q   <= '0;
                        bit_q   <= '0;
                        state_q <= rxd ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cnt_q <= '0;
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == 3'd7)
                            state_q <= RX_STOP;
                    end
                end
                default: begin    // RX_STOP
                    if (bit_end) begin
                        valid_q <= rxd;    // framing error drops the byte
                        state_q <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk_i) begin
        if (state_q == RX_DATA && bit_end)
            shift_q <= {rxd, shift_q[7:1]};
    end

    assign rx_valid_o = valid_q;
    assign rx_byte_o  = shift_q;

endmodule

//--- verilog/uart_tx.sv
////////////////////////////////////////////////////////////
// uart_tx
// 8N1 transmitter built around a 10 bit shift register
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module uart_tx
    import link_pkg::*;
#(
    parameter int CLK_FREQ  = 100_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  tx_valid_i,
    input  byte_t tx_byte_i,
    output logic  tx_ready_o,
    output logic  txd_o
);

    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);

    logic [9:0]       shift_q;     // stop, data, start
    logic [3:0]       bits_left_q;
    logic [CNT_W-1:0] cnt_q;
    logic             ready_q;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            shift_q     <= '1;
            bits_left_q <= '0;
            cnt_q       <= '0;
            ready_q     <= 1'b0;
        end else if (ready_q) begin
            if (tx_valid_i) begin
                shift_q     <= {1'b1, tx_byte_i, 1'b0};
                bits_left_q <= 4'd10;
                cnt_q       <= '0;
                ready_q     <= 1'b0;
            end
        end else if (bits_left_q == '0) begin
            ready_q <= 1'b1;    // line back to idle
        end else if (cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
            cnt_q       <= '0;
            shift_q     <= {1'b1, shift_q[9:1]};    // fill with idle level
            bits_left_q <= bits_left_q - 1'b1;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign tx_ready_o = ready_q;
    assign txd_o      = shift_q[0];

endmodule

//--- verilog/cmd_parser.sv
////////////////////////////////////////////////////////////
// cmd_parser
// decodes debug frames and issues word-sized bus requests
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module cmd_parser
    import link_pkg::*;
    import bus_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     rx_valid_i,
    input  byte_t    rx_byte_i,
    output logic     req_valid_o,
    input  logic     req_ready_i,
    output bus_req_t req_o,
    output logic     read_start_o,
    output len_t     read_len_o,
    input  logic     word_taken_i,
    input  logic     read_done_i
);

    localparam int    LANE_W    = $clog2(BYTES_PER_WORD);
    localparam len_t  WORD_LEN  = len_t'(BYTES_PER_WORD);
    localparam addr_t ADDR_STEP = addr_t'(BYTES_PER_WORD);

    typedef enum logic [2:0] {P_IDLE, P_LEN, P_ADDR, P_WRITE, P_READ} pstate_t;

    pstate_t           state_q;
    logic              is_write_q;
    len_t              len_q;       // bytes still to collect or fetch
    logic [1:0]        addr_idx_q;
    logic [LANE_W-1:0] lane_q;
    addr_t             addr_q;
    data_t             word_q;
    data_t             word_next;
    bus_req_t          req_q;
    logic              req_valid_q;
    logic              read_start_q;
    len_t              read_len_q;
    addr_t             req_addr;
    logic              hdr_last, wr_issue, rd_first, rd_next, issue;

    assign hdr_last = (state_q == P_ADDR) && rx_valid_i && (addr_idx_q == 2'd3);
    assign wr_issue = (state_q == P_WRITE) && rx_valid_i &&
                      ((lane_q == LANE_W'(BYTES_PER_WORD - 1)) || (len_q == len_t'(1)));
    assign rd_first = hdr_last && !is_write_q && (len_q != '0);
    assign rd_next  = (state_q == P_READ) && word_taken_i && (len_q != '0);
    assign issue    = wr_issue || rd_first || rd_next;

    // header address is still being shifted in on the first read
    assign req_addr = (state_q == P_ADDR) ? {addr_q[23:0], rx_byte_i} : addr_q;

    always_comb begin
        word_next = word_q;
        word_next[lane_q*8 +: 8] = rx_byte_i;    // little-endian lanes
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state_q      <= P_IDLE;
            is_write_q   <= 1'b0;
            len_q        <= '0;
            addr_idx_q   <= '0;
            lane_q       <= '0;
            req_valid_q  <= 1'b0;
            read_start_q <= 1'b0;
        end else begin
            case (state_q)
                P_IDLE: begin
                    // anything but a command byte is dropped
                    if (rx_valid_i && (rx_byte_i == CMD_WRITE || rx_byte_i == CMD_READ)) begin
                        is_write_q <= (rx_byte_i == CMD_WRITE);
                        state_q    <= P_LEN;
                    end
                end
                P_LEN: begin
                    if (rx_valid_i) begin
                        len_q      <= rx_byte_i;
                        addr_idx_q <= '0;
                        state_q    <= P_ADDR;
                    end
                end
                P_ADDR: begin
                    if (rx_valid_i)
                        addr_idx_q <= addr_idx_q + 1'b1;
                    if (hdr_last) begin
                        lane_q <= '0;
                        if (len_q == '0)
                            state_q <= P_IDLE;    // empty frame
                        else
                            state_q <= is_write_q ? P_WRITE : P_READ;
                    end
                end
                P_WRITE: begin
                    if (rx_valid_i) begin
                        len_q  <= len_q - 1'b1;
                        lane_q <= wr_issue ? '0 : lane_q + 1'b1;
                        if (len_q == len_t'(1))
                            state_q <= P_IDLE;
                    end
                end
                P_READ: begin
                    if (read_done_i)
                        state_q <= P_IDLE;
                end
                default: state_q <= P_IDLE;
            endcase

            if (rd_first || rd_next)
                len_q <= (len_q > WORD_LEN) ? len_q - WORD_LEN : '0;
            read_start_q <= rd_first;

            if (req_valid_q && req_ready_i)
                req_valid_q <= 1'b0;
            if (issue)
                req_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == P_ADDR && rx_valid_i)
            addr_q <= {addr_q[23:0], rx_byte_i};    // msb first
        if (state_q == P_ADDR)
            word_q <= '0;
        else if (state_q == P_WRITE && rx_valid_i)
            word_q <= wr_issue ? '0 : word_next;
        if (rd_first)
            read_len_q <= len_q;
        if (issue) begin
            req_q.write <= is_write_q;
            req_q.addr  <= req_addr;
            req_q.data  <= is_write_q ? word_next : '0;
            addr_q      <= req_addr + ADDR_STEP;
        end
    end

    assign req_valid_o  = req_valid_q;
    assign req_o        = req_q;
    assign read_start_o = read_start_q;
    assign read_len_o   = read_len_q;

endmodule

//--- verilog/bus_master.sv
////////////////////////////////////////////////////////////
// bus_master
// runs one single-beat AXI read or write per request
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module bus_master
    import bus_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    input  bus_req_t req_i,
    output logic     rd_valid_o,
    input  logic     rd_ready_i,
    output data_t    rd_data_o,
    output logic     awvalid_o,
    input  logic     awready_i,
    output addr_t    awaddr_o,
    output logic     wvalid_o,
    input  logic     wready_i,
    output data_t    wdata_o,
    input  logic     bvalid_i,
    output logic     bready_o,
    output logic     arvalid_o,
    input  logic     arready_i,
    output addr_t    araddr_o,
    input  logic     rvalid_i,
    output logic     rready_o,
    input  data_t    rdata_i
);

    typedef enum logic [1:0] {M_IDLE, M_WRITE, M_READ, M_HOLD} mstate_t;

    mstate_t  state_q;
    bus_req_t req_q;
    data_t    rd_data_q;
    logic     ready_q, rd_valid_q;
    logic     awvalid_q, wvalid_q, bready_q, arvalid_q, rready_q;
    logic     accept;
    addr_t    word_addr;

    assign accept    = req_valid_i && ready_q;
    assign word_addr = {req_q.addr[$bits(addr_t)-1:2], 2'b00};    // word aligned

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state_q    <= M_IDLE;
            ready_q    <= 1'b0;
            rd_valid_q <= 1'b0;
            awvalid_q  <= 1'b0;
            wvalid_q   <= 1'b0;
            bready_q   <= 1'b0;
            arvalid_q  <= 1'b0;
            rready_q   <= 1'b0;
        end else begin
            case (state_q)
                M_IDLE: begin
                    ready_q <= !accept;
                    if (accept && req_i.write) begin
                        awvalid_q <= 1'b1;    // address and data start together
                        wvalid_q  <= 1'b1;
                        bready_q  <= 1'b1;
                        state_q   <= M_WRITE;
                    end else if (accept) begin
                        arvalid_q <= 1'b1;
                        rready_q  <= 1'b1;
                        state_q   <= M_READ;
                    end
                end
                M_WRITE: begin
                    if (awready_i)
                        awvalid_q <= 1'b0;
                    if (wready_i)
                        wvalid_q <= 1'b0;
                    if (bvalid_i && bready_q) begin
                        bready_q <= 1'b0;
                        ready_q  <= 1'b1;
                        state_q  <= M_IDLE;
                    end
                end
                M_READ: begin
                    if (arready_i)
                        arvalid_q <= 1'b0;
                    if (rvalid_i && rready_q) begin
                        rready_q   <= 1'b0;
                        rd_valid_q <= 1'b1;
                        state_q    <= M_HOLD;
                    end
                end
                default: begin    // M_HOLD, wait for the serializer
                    if (rd_ready_i) begin
                        rd_valid_q <= 1'b0;
                        ready_q    <= 1'b1;
                        state_q    <= M_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept)
            req_q <= req_i;
        if (rvalid_i && rready_q)
            rd_data_q <= rdata_i;
    end

    assign req_ready_o = ready_q;
    assign rd_valid_o  = rd_valid_q;
    assign rd_data_o   = rd_data_q;
    assign awvalid_o   = awvalid_q;
    assign awaddr_o    = word_addr;
    assign wvalid_o    = wvalid_q;
    assign wdata_o     = req_q.data;
    assign bready_o    = bready_q;
    assign arvalid_o   = arvalid_q;
    assign araddr_o    = word_addr;
    assign rready_o    = rready_q;

endmodule

//--- verilog/resp_serializer.sv
////////////////////////////////////////////////////////////
// resp_serializer
// splits read words into bytes for the UART, low byte first
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module resp_serializer
    import link_pkg::*;
    import bus_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  read_start_i,
    input  len_t  read_len_i,
    input  logic  rd_valid_i,
    output logic  rd_ready_o,
    input  data_t rd_data_i,
    output logic  rd_taken_o,
    output logic  tx_valid_o,
    input  logic  tx_ready_i,
    output byte_t tx_byte_o,
    output logic  read_done_o
);

    localparam int LANES_W = $clog2(BYTES_PER_WORD + 1);

    len_t               remain_q;    // bytes left in this read
    logic [LANES_W-1:0] lanes_q;     // bytes left in the held word
    data_t              word_q;
    logic               done_q;
    logic               tx_take;

    assign rd_ready_o = (lanes_q == '0) && (remain_q != '0);
    assign rd_taken_o = rd_valid_i && rd_ready_o;
    assign tx_valid_o = (lanes_q != '0);
    assign tx_take    = tx_valid_o && tx_ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            remain_q <= '0;
            lanes_q  <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (read_start_i) begin
                remain_q <= read_len_i;
            end else if (tx_take) begin
                remain_q <= remain_q - 1'b1;
                // a short last word drops its unused lanes
                lanes_q  <= (remain_q == len_t'(1)) ? '0 : lanes_q - 1'b1;
                done_q   <= (remain_q == len_t'(1));
            end else if (rd_taken_o) begin
                lanes_q <= LANES_W'(BYTES_PER_WORD);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_taken_o)
            word_q <= rd_data_i;
        else if (tx_take)
            word_q <= word_q >> $bits(byte_t);
    end

    assign tx_byte_o   = word_q[$bits(byte_t)-1:0];
    assign read_done_o = done_q;

endmodule

//--- verilog/dbg_bridge.sv
////////////////////////////////////////////////////////////
// dbg_bridge
// UART command frames to single-beat AXI reads and writes
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dbg_bridge
    import link_pkg::*;
    import bus_pkg::*;
#(
    parameter int CLK_FREQ  = 100_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  uart_rxd_i,
    output logic  uart_txd_o,
    output logic  awvalid_o,
    input  logic  awready_i,
    output addr_t awaddr_o,
    output logic  wvalid_o,
    input  logic  wready_i,
    output data_t wdata_o,
    input  logic  bvalid_i,
    output logic  bready_o,
    output logic  arvalid_o,
    input  logic  arready_i,
    output addr_t araddr_o,
    input  logic  rvalid_i,
    output logic  rready_o,
    input  data_t rdata_i
);

    logic     rx_valid, req_valid, req_ready, read_start, read_done;
    logic     rd_valid, rd_ready, rd_taken, tx_valid, tx_ready;
    byte_t    rx_byte, tx_byte;
    bus_req_t req;
    len_t     read_len;
    data_t    rd_data;

    uart_rx #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)) u_rx (
        .clk_i(clk_i), .rst_i(rst_i), .rxd_i(uart_rxd_i),
        .rx_valid_o(rx_valid), .rx_byte_o(rx_byte)
    );

    cmd_parser u_parser (
        .clk_i(clk_i), .rst_i(rst_i),
        .rx_valid_i(rx_valid), .rx_byte_i(rx_byte),
        .req_valid_o(req_valid), .req_ready_i(req_ready), .req_o(req),
        .read_start_o(read_start), .read_len_o(read_len),
        .word_taken_i(rd_taken), .read_done_i(read_done)
    );

    bus_master u_master (
        .clk_i(clk_i), .rst_i(rst_i),
        .req_valid_i(req_valid), .req_ready_o(req_ready), .req_i(req),
        .rd_valid_o(rd_valid), .rd_ready_i(rd_ready), .rd_data_o(rd_data),
        .awvalid_o(awvalid_o), .awready_i(awready_i), .awaddr_o(awaddr_o),
        .wvalid_o(wvalid_o), .wready_i(wready_i), .wdata_o(wdata_o),
        .bvalid_i(bvalid_i), .bready_o(bready_o),
        .arvalid_o(arvalid_o), .arready_i(arready_i), .araddr_o(araddr_o),
        .rvalid_i(rvalid_i), .rready_o(rready_o), .rdata_i(rdata_i)
    );

    // rd_taken paces the parser's next read request
    resp_serializer u_ser (
        .clk_i(clk_i), .rst_i(rst_i),
        .read_start_i(read_start), .read_len_i(read_len),
        .rd_valid_i(rd_valid), .rd_ready_o(rd_ready), .rd_data_i(rd_data),
        .rd_taken_o(rd_taken),
        .tx_valid_o(tx_valid), .tx_ready_i(tx_ready), .tx_byte_o(tx_byte),
        .read_done_o(read_done)
    );

    uart_tx #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)) u_tx (
        .clk_i(clk_i), .rst_i(rst_i),
        .tx_valid_i(tx_valid), .tx_byte_i(tx_byte),
        .tx_ready_o(tx_ready), .txd_o(uart_txd_o)
    );

endmodule

//--- bench/dbg_bridge_properties.sv
////////////////////////////////////////////////////////////
// dbg_bridge_properties
// AXI handshake and UART idle checks bound to the bridge
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dbg_bridge_properties
    import bus_pkg::*;
(
    input logic  clk_i,
    input logic  rst_i,
    input logic  txd_i,
    input logic  awvalid_i,
    input logic  awready_i,
    input addr_t awaddr_i,
    input logic  wvalid_i,
    input logic  wready_i,
    input data_t wdata_i,
    input logic  arvalid_i,
    input logic  arready_i,
    input addr_t araddr_i
);

    int fire_count = 0;    // read by the testbench at the end of the run

    aw_held: assert property (@(posedge clk_i) disable iff (rst_i)
        awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
        else begin fire_count++; $error("awvalid_o or awaddr_o changed before awready_i"); end

    w_held: assert property (@(posedge clk_i) disable iff (rst_i)
        wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i))
        else begin fire_count++; $error("wvalid_o or wdata_o changed before wready_i"); end

    ar_held: assert property (@(posedge clk_i) disable iff (rst_i)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
        else begin fire_count++; $error("arvalid_o or araddr_o changed before arready_i"); end

    aw_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        awvalid_i |-> awaddr_i[1:0] == 2'b00)
        else begin fire_count++; $error("awaddr_o low bits not zero"); end

    ar_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        arvalid_i |-> araddr_i[1:0] == 2'b00)
        else begin fire_count++; $error("araddr_o low bits not zero"); end

    // address and data phases of a write open in the same cycle
    aw_w_together: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(awvalid_i) == $rose(wvalid_i))
        else begin fire_count++; $error("awvalid_o and wvalid_o did not rise together"); end

    txd_idle_in_reset: assert property (@(posedge clk_i)
        rst_i && $past(rst_i) |-> txd_i)
        else begin fire_count++; $error("uart_txd_o low during reset"); end

endmodule

bind dbg_bridge dbg_bridge_properties u_props (
    .clk_i(clk_i), .rst_i(rst_i), .txd_i(uart_txd_o),
    .awvalid_i(awvalid_o), .awready_i(awready_i), .awaddr_i(awaddr_o),
    .wvalid_i(wvalid_o), .wready_i(wready_i), .wdata_i(wdata_o),
    .arvalid_i(arvalid_o), .arready_i(arready_i), .araddr_i(araddr_o)
);

//--- bench/tb_dbg_bridge.sv
////////////////////////////////////////////////////////////
// tb_dbg_bridge
// UART host, AXI memory model and directed tests for the bridge
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_dbg_bridge
    import link_pkg::*;
    import bus_pkg::*;
();

    localparam int CLK_FREQ  = 250_000_000;
    localparam int BAUD_RATE = 25_000_000;
    localparam int BIT_CLKS  = CLK_FREQ / BAUD_RATE;
    localparam int BYTE_NS   = 10 * BIT_CLKS * 4;    // 10 bits at a 4 ns clock
    localparam int FRAME_NS  = 18 * BYTE_NS;         // longest frame, 6 header + 12 data
    localparam int NUM_TESTS = 6;
    localparam int MEM_WORDS = 16;

    logic  clk = 1'b0;
    logic  rst;
    logic  uart_rxd, uart_txd;
    logic  awvalid, awready, wvalid, wready, bvalid, bready;
    logic  arvalid, arready, rvalid, rready;
    addr_t awaddr, araddr;
    data_t wdata, rdata;

    data_t       mem [MEM_WORDS];
    logic [31:0] lfsr_q = 32'h7049_e62b;
    byte_t       payload_q[$], reply_q[$], expect_q[$], w8_q[$], w3_q[$];
    int          errors = 0;
    int          checks = 0;
    int          test_no = 0;
    int          test_errs = 0;
    int          total;
    logic        reply_seen = 1'b0;

    dbg_bridge #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)) u_dut (
        .clk_i(clk), .rst_i(rst), .uart_rxd_i(uart_rxd), .uart_txd_o(uart_txd),
        .awvalid_o(awvalid), .awready_i(awready), .awaddr_o(awaddr),
        .wvalid_o(wvalid), .wready_i(wready), .wdata_o(wdata),
        .bvalid_i(bvalid), .bready_o(bready),
        .arvalid_o(arvalid), .arready_i(arready), .araddr_o(araddr),
        .rvalid_i(rvalid), .rready_o(rready), .rdata_i(rdata)
    );

    always #2 clk = ~clk;

    // galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[6:0], lfsr_bit()};
        return v;
    endfunction

    // little-endian word from a byte list, missing lanes read as zero
    function automatic data_t pack_word(input byte_t q[$], input int base);
        data_t w;
        w = '0;
        for (int i = 0; i < BYTES_PER_WORD; i++)
            if (base + i < q.size())
                w[i*8 +: 8] = q[base + i];
        return w;
    endfunction

    task automatic random_delay();
        repeat (rand_bits(2)) @(negedge clk);    // 0 to 3 cycles
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Fail %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    // memory model, write side
    initial begin
        addr_t wa;
        data_t wd;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = {16'hc0de, 16'(i * 4)};
        forever begin
            @(negedge clk);
            if (awvalid) begin
                random_delay();
                awready = 1'b1;
                wa      = awaddr;
                @(negedge clk);
                awready = 1'b0;
                random_delay();
                wready = 1'b1;    // wvalid still held from the address cycle
                wd     = wdata;
                @(negedge clk);
                wready = 1'b0;
                random_delay();
                bvalid         = 1'b1;
                mem[wa[5:2]]   = wd;
                @(negedge clk);
                bvalid = 1'b0;
            end
        end
    end

    // memory model, read side
    initial begin
        addr_t ra;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        forever begin
            @(negedge clk);
            if (arvalid) begin
                random_delay();
                arready = 1'b1;
                ra      = araddr;
                @(negedge clk);
                arready = 1'b0;
                random_delay();
                rvalid = 1'b1;
                rdata  = mem[ra[5:2]];
                @(negedge clk);
                rvalid = 1'b0;
            end
        end
    end

    // line must stay idle until a read is under way
    always @(negedge clk) begin
        if (!rst && !reply_seen) begin
            assert (uart_txd) else begin
                errors++;
                $display("uart_txd_o left idle before the first read reply");
            end
        end
    end

    task automatic send_byte(input byte_t b);
        uart_rxd = 1'b0;
        repeat (BIT_CLKS) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            uart_rxd = b[i];    // lsb first
            repeat (BIT_CLKS) @(negedge clk);
        end
        uart_rxd = 1'b1;
        repeat (BIT_CLKS) @(negedge clk);
    endtask

    task automatic send_header(input byte_t cmd, input len_t len, input addr_t addr);
        send_byte(cmd);
        send_byte(len);
        for (int i = 3; i >= 0; i--)
            send_byte(addr[i*8 +: 8]);
    endtask

    task automatic receive_byte(output byte_t b);
        @(negedge clk);
        while (uart_txd)
            @(negedge clk);
        repeat (BIT_CLKS / 2) @(negedge clk);    // middle of start bit
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            b[i] = uart_txd;
        end
        repeat (BIT_CLKS) @(negedge clk);
        check_value("uart_txd_o stop bit", 1, uart_txd);
    endtask

    task automatic write_frame(input addr_t addr, input int n);
        payload_q.delete();
        for (int i = 0; i < n; i++)
            payload_q.push_back(rand_bits(8));
        send_header(CMD_WRITE, len_t'(n), addr);
        foreach (payload_q[i])
            send_byte(payload_q[i]);
    endtask

    task automatic read_frame(input addr_t addr, input int n);
        byte_t b;
        reply_q.delete();
        reply_seen = 1'b1;
        fork
            send_header(CMD_READ, len_t'(n), addr);
            for (int i = 0; i < n; i++) begin
                receive_byte(b);
                reply_q.push_back(b);
            end
        join
    endtask

    task automatic check_reply();
        foreach (expect_q[i])
            check_value($sformatf("uart_txd_o byte %0d", i), expect_q[i], reply_q[i]);
    endtask

    task automatic start_test();
        test_no++;
        test_errs = errors;
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s: %s", test_no, name,
                 (errors == test_errs) ? "passed" : "FAILED");
    endtask

    initial begin
        rst      = 1'b1;
        uart_rxd = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        start_test();
        repeat (20) @(negedge clk);
        check_value("awvalid_o", 0, awvalid);
        check_value("wvalid_o", 0, wvalid);
        check_value("arvalid_o", 0, arvalid);
        check_value("bready_o", 0, bready);
        check_value("rready_o", 0, rready);
        check_value("uart_txd_o", 1, uart_txd);
        end_test("reset state");

        start_test();
        write_frame(32'h8, 8);
        w8_q = payload_q;
        read_frame(32'h8, 8);
        expect_q = w8_q;
        check_reply();
        check_value("mem[2]", pack_word(w8_q, 0), mem[2]);
        check_value("mem[3]", pack_word(w8_q, 4), mem[3]);
        end_test("write 8, read 8 at 0x8");

        start_test();
        write_frame(32'h20, 3);
        w3_q = payload_q;
        read_frame(32'h20, 4);
        expect_q = w3_q;
        expect_q.push_back(8'h00);    // unfilled lane of the partial word
        check_reply();
        check_value("mem[8]", pack_word(w3_q, 0), mem[8]);
        end_test("write 3, read 4 at 0x20");

        start_test();
        read_frame(32'h23, 4);
        check_reply();
        end_test("read 4 at 0x23");

        start_test();
        send_byte(8'h55);
        read_frame(32'h8, 4);
        expect_q.delete();
        for (int i = 0; i < 4; i++)
            expect_q.push_back(w8_q[i]);
        check_reply();
        end_test("stray byte before read");

        start_test();
        write_frame(32'h30, 12);
        expect_q = payload_q;
        read_frame(32'h30, 12);
        check_reply();
        for (int i = 0; i < 3; i++)
            check_value($sformatf("mem[%0d]", 12 + i), pack_word(expect_q, i * 4), mem[12 + i]);
        end_test("write 12, read 12 at 0x30");

        total = errors + u_dut.u_props.fire_count;
        $display("%0d tests, %0d checks, %0d check errors, %0d property failures",
                 test_no, checks, errors, u_dut.u_props.fire_count);
        if (total == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // forty frame times per test
    initial begin
        #(NUM_TESTS * 40 * FRAME_NS);
        $display("timeout: the tests did not finish within %0d ns", NUM_TESTS * 40 * FRAME_NS);
        $display("Errors found");
        $finish;
    end

endmodule

//--- flist.f
verilog/link_pkg.sv
verilog/bus_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/cmd_parser.sv
verilog/bus_master.sv
verilog/resp_serializer.sv
verilog/dbg_bridge.sv
bench/dbg_bridge_properties.sv
bench/tb_dbg_bridge.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dbg_bridge
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
